// File: background/bg_fetch.sv
////////////////////////////////////////////////////////////
// Builds the 32 tile words of the next line during the
// fetch columns and writes them to the line buffer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bg_fetch (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                CE,
  vid_regs_if.sink            regs,
  raster_if.sink              raster,
  output tv1_pkg::bgm_addr_t  fetch_bgm_addr,
  output tv1_pkg::chr_addr_t  fetch_chr_addr,
  input  tv1_pkg::byte_t      bgm_rdata,
  input  tv1_pkg::byte_t      chr_rdata,
  output logic                lb_we,
  output logic [5:0]          lb_waddr,
  output tv1_pkg::line_word_t lb_wdata
);

  tv1_pkg::coord_t     next_row;
  logic [4:0]          tx;
  logic [4:0]          ty;
  logic                in_fetch;
  logic                ch_area;
  logic [3:0]          ce_d;
  logic [1:0]          hi_bits;
  logic [3:0]          lo_nib;
  tv1_pkg::color_t     bg_sel;
  tv1_pkg::color_t     fg_sel;
  logic [7:0]          pat_sel;
  logic [7:0]          pat;
  tv1_pkg::line_word_t word;
  // Stage A tile position, stage B memory byte, stage C colors
  logic                a_valid, a_bank, a_ch, a_odd;
  logic [4:0]          a_tile;
  logic [3:0]          a_rsub;
  logic                b_valid, b_bank, b_use_chr;
  logic [4:0]          b_tile;
  logic [2:0]          b_rsub;
  logic [6:0]          b_chr;
  tv1_pkg::color_t     b_bg, b_fg;
  logic [7:0]          b_pat;
  logic                c_valid, c_bank, c_use_chr;
  logic [4:0]          c_tile;
  tv1_pkg::color_t     c_bg, c_fg;
  logic [7:0]          c_pat;

  assign next_row = raster.row + 9'd1;
  assign tx       = raster.col[4:0];
  assign ty       = next_row[7:3];
  assign in_fetch = raster.fetch_row && (raster.col <= tv1_pkg::FETCH_LAST_COL);
  assign ch_area  = ((tx[4:1] < regs.bm_xmax) ^ regs.bm_invx)
                    & ((ty[4:1] < regs.bm_ymax) ^ regs.bm_invy);

  assign fetch_bgm_addr = {ty[4:1], tx};
  assign fetch_chr_addr = {b_chr, b_rsub};

  ////////////////////////////////////////////////////////////
  // Color and pattern decision on the memory byte

  assign hi_bits = bgm_rdata[{~a_rsub[3:2], 1'b0} +: 2];
  assign lo_nib  = bgm_rdata[{~a_rsub[3], 2'b00} +: 4];

  always_comb begin
    bg_sel  = regs.bm_clr_bg;
    fg_sel  = regs.bm_clr_fg;
    pat_sel = '0;
    if (a_ch) begin
      bg_sel = regs.ch_clr_bg;
      fg_sel = regs.ch_clr_fg;
    end else if (regs.bm_ena && regs.bm_lores) begin
      bg_sel = lo_nib;
    end else if (regs.bm_ena) begin
      pat_sel = {{4{hi_bits[1]}}, {4{hi_bits[0]}}};
    end
  end

  // Pixel k takes pattern bit 7-k
  always_comb begin
    pat = c_use_chr ? chr_rdata : c_pat;
    for (int k = 0; k < 8; k++) begin
      word[k*4 +: 4] = pat[7-k] ? c_fg : c_bg;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pipeline, each stage one clock behind the one before
  // Memories read every clock, so a stage waits one clock for them

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ce_d    <= '0;
      a_valid <= 1'b0;
      b_valid <= 1'b0;
      c_valid <= 1'b0;
      lb_we   <= 1'b0;
    end else begin
      ce_d <= {ce_d[2:0], CE};
      if (ce_d[0]) a_valid <= in_fetch;
      if (ce_d[1]) b_valid <= a_valid;
      if (ce_d[2]) c_valid <= b_valid;
      lb_we <= ce_d[3] & c_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (ce_d[0]) begin
      a_tile <= tx;
      a_bank <= ~raster.row[0];
      a_rsub <= next_row[3:0];
      a_odd  <= ty[0];
      a_ch   <= ch_area;
    end
    if (ce_d[1]) begin
      b_tile    <= a_tile;
      b_bank    <= a_bank;
      b_rsub    <= a_rsub[2:0];
      b_chr     <= bgm_rdata[6:0];
      b_use_chr <= a_ch & ~a_odd;
      b_bg      <= bg_sel;
      b_fg      <= fg_sel;
      b_pat     <= pat_sel;
    end
    if (ce_d[2]) begin
      c_tile    <= b_tile;
      c_bank    <= b_bank;
      c_use_chr <= b_use_chr;
      c_bg      <= b_bg;
      c_fg      <= b_fg;
      c_pat     <= b_pat;
    end
    if (ce_d[3]) begin
      lb_waddr <= {c_bank, c_tile};
      lb_wdata <= word;
    end
  end

endmodule

// File: background/line_buffer.sv
////////////////////////////////////////////////////////////
// Ping-pong line buffer of 8-pixel words. The fetch fills
// one bank while the raster reads the other
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module line_buffer (
  input  logic                CLK,
  input  logic                CE,
  input  logic                lb_we,
  input  logic [5:0]          lb_waddr,
  input  tv1_pkg::line_word_t lb_wdata,
  raster_if.sink              raster,
  output tv1_pkg::color_t     px
);

  // Bank in the top address bit
  tv1_pkg::line_word_t mem [2*tv1_pkg::NUM_TILES];
  tv1_pkg::line_word_t rd_word;
  logic [2:0]          sel_d;

  always_ff @(posedge CLK) begin
    if (lb_we) begin
      mem[lb_waddr] <= lb_wdata;
    end
  end

  // New word at every tile boundary
  always_ff @(posedge CLK) begin
    if (CE) begin
      if (raster.col[2:0] == 3'd0) begin
        rd_word <= mem[{raster.row[0], raster.col[7:3]}];
      end
      sel_d <= raster.col[2:0];
    end
  end

  assign px = rd_word[{sel_d, 2'b00} +: 4];

endmodule

// File: background/tile_memory.sv
////////////////////////////////////////////////////////////
// Background memory and character pattern ROM, both with a
// registered read on every clock
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tile_memory (
  input  logic               CLK,
  input  tv1_pkg::cpu_addr_t a,
  input  tv1_pkg::byte_t     db_i,
  input  logic               cpu_bgm_sel,
  input  logic               cpu_bgm_we,
  input  tv1_pkg::bgm_addr_t fetch_bgm_addr,
  input  tv1_pkg::chr_addr_t fetch_chr_addr,
  output tv1_pkg::byte_t     bgm_rdata,
  output tv1_pkg::byte_t     chr_rdata,
  input  logic               rominit_sel_chr,
  input  tv1_pkg::chr_addr_t rominit_addr,
  input  tv1_pkg::byte_t     rominit_data,
  input  logic               rominit_valid
);

  tv1_pkg::byte_t     bgm [512];
  tv1_pkg::byte_t     chr [1024];
  tv1_pkg::bgm_addr_t bgm_addr;

  // A CPU access takes the port over from the fetch
  assign bgm_addr = cpu_bgm_sel ? a[8:0] : fetch_bgm_addr;

  always_ff @(posedge CLK) begin
    if (cpu_bgm_we) begin
      bgm[bgm_addr] <= db_i;
    end
    bgm_rdata <= bgm[bgm_addr];
  end

  // Pattern ROM is only written by the load port
  always_ff @(posedge CLK) begin
    if (rominit_sel_chr && rominit_valid) begin
      chr[rominit_addr] <= rominit_data;
    end
    chr_rdata <= chr[fetch_chr_addr];
  end

endmodule

// File: common/raster_if.sv
////////////////////////////////////////////////////////////
// Raster position and region flags from the timing block
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface raster_if;

  tv1_pkg::coord_t row;
  tv1_pkg::coord_t col;
  // Rows that prepare the next displayed line
  logic            fetch_row;
  logic            render_px;

  modport src (output row, col, fetch_row, render_px);

  modport sink (input row, col, fetch_row, render_px);

endinterface

// File: common/tv1_pkg.sv
////////////////////////////////////////////////////////////
// Raster geometry, address map, widths and palette of the
// TV-1 background video core, reached as tv1_pkg::name
////////////////////////////////////////////////////////////

package tv1_pkg;

  typedef logic [8:0]  coord_t;
  typedef logic [12:0] cpu_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  color_t;
  typedef logic [23:0] rgb_t;
  typedef logic [31:0] line_word_t;
  typedef logic [8:0]  bgm_addr_t;
  typedef logic [9:0]  chr_addr_t;

  ////////////////////////////////////////////////////////////
  // Raster geometry

  localparam coord_t NUM_COLS           = 9'd260;
  localparam coord_t NUM_ROWS           = 9'd262;
  localparam coord_t FIRST_ROW_RENDER   = 9'd21;
  localparam coord_t LAST_ROW_RENDER    = 9'd242;
  localparam coord_t FIRST_COL_RENDER   = 9'd28;
  localparam coord_t LAST_COL_RENDER    = 9'd219;
  localparam coord_t LAST_COL_HSYNC     = 9'd19;
  localparam coord_t FIRST_ROW_VSYNC    = 9'd253;
  localparam coord_t LAST_ROW_VSYNC     = 9'd261;
  // Row that fills the first displayed line
  localparam coord_t FIRST_ROW_PREFETCH = 9'd20;
  localparam int     NUM_TILES          = 32;
  localparam coord_t FETCH_LAST_COL     = 9'd31;

  ////////////////////////////////////////////////////////////
  // CPU address map

  localparam cpu_addr_t ADDR_BGM_BASE = 13'h1000;
  localparam cpu_addr_t ADDR_REG_BASE = 13'h1400;

  ////////////////////////////////////////////////////////////
  // Colors, packed as red, green, blue

  localparam color_t BORDER_COLOR = 4'd1;

  localparam rgb_t PALETTE [16] = '{
    24'h00009b, 24'h000000, 24'h0000ff, 24'ha100ff,
    24'h00ff00, 24'ha0ff9d, 24'h00ffff, 24'h00a100,
    24'hff0000, 24'hffa100, 24'hff00ff, 24'hffa09f,
    24'hffff00, 24'ha3a000, 24'ha1a09d, 24'hffffff
  };

endpackage

// File: common/vid_regs_if.sv
////////////////////////////////////////////////////////////
// Decoded control register fields, driven by the host port
// and read by the background fetch
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface vid_regs_if;

  logic            bm_ena;
  logic            bm_lores;
  logic            bm_invx;
  logic            bm_invy;
  tv1_pkg::color_t bm_clr_bg;
  tv1_pkg::color_t bm_clr_fg;
  logic [3:0]      bm_xmax;
  logic [3:0]      bm_ymax;
  tv1_pkg::color_t ch_clr_bg;
  tv1_pkg::color_t ch_clr_fg;

  modport src (output bm_ena, bm_lores, bm_invx, bm_invy, bm_clr_bg, bm_clr_fg,
               bm_xmax, bm_ymax, ch_clr_bg, ch_clr_fg);

  modport sink (input bm_ena, bm_lores, bm_invx, bm_invy, bm_clr_bg, bm_clr_fg,
                bm_xmax, bm_ymax, ch_clr_bg, ch_clr_fg);

endinterface

// File: logic/color_out.sv
////////////////////////////////////////////////////////////
// Black border outside the render area and the registered
// palette lookup that drives RGB
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module color_out (
  input  logic            CLK,
  input  logic            arst_n,
  input  logic            CE,
  input  tv1_pkg::color_t px,
  raster_if.sink          raster,
  output tv1_pkg::rgb_t   rgb
);

  logic            render_px_d;
  tv1_pkg::color_t pd;

  // px trails the column counter by one step
  assign pd = render_px_d ? px : tv1_pkg::BORDER_COLOR;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      render_px_d <= 1'b0;
      rgb         <= '0;
    end else if (CE) begin
      render_px_d <= raster.render_px;
      rgb         <= tv1_pkg::PALETTE[pd];
    end
  end

endmodule

// File: logic/epoch_tv1.sv
////////////////////////////////////////////////////////////
// Top level of the TV-1 background video core. Connects the
// CPU port, timing, fetch, line buffer and color output
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module epoch_tv1 (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               CE,
  input  logic               rominit_sel_chr,
  input  tv1_pkg::chr_addr_t rominit_addr,
  input  tv1_pkg::byte_t     rominit_data,
  input  logic               rominit_valid,
  input  tv1_pkg::cpu_addr_t a,
  input  tv1_pkg::byte_t     db_i,
  input  logic               rdb,
  input  logic               wrb,
  input  logic               csb,
  output tv1_pkg::byte_t     db_o,
  output logic               db_oe,
  output logic               vbl,
  output logic               de,
  output logic               hs,
  output logic               vs,
  output tv1_pkg::rgb_t      rgb
);

  logic                cpu_bgm_sel;
  logic                cpu_bgm_we;
  tv1_pkg::byte_t      bgm_rdata;
  tv1_pkg::byte_t      chr_rdata;
  tv1_pkg::bgm_addr_t  fetch_bgm_addr;
  tv1_pkg::chr_addr_t  fetch_chr_addr;
  logic                lb_we;
  logic [5:0]          lb_waddr;
  tv1_pkg::line_word_t lb_wdata;
  tv1_pkg::color_t     px;

  vid_regs_if regs ();
  raster_if   raster ();

  host_port i_host_port (
    .CLK(CLK), .arst_n(arst_n), .CE(CE),
    .a(a), .db_i(db_i), .rdb(rdb), .wrb(wrb), .csb(csb),
    .db_o(db_o), .db_oe(db_oe),
    .cpu_bgm_sel(cpu_bgm_sel), .cpu_bgm_we(cpu_bgm_we),
    .bgm_rdata(bgm_rdata), .regs(regs)
  );

  video_timing i_video_timing (
    .CLK(CLK), .arst_n(arst_n), .CE(CE),
    .vbl(vbl), .de(de), .hs(hs), .vs(vs), .raster(raster)
  );

  tile_memory i_tile_memory (
    .CLK(CLK), .a(a), .db_i(db_i),
    .cpu_bgm_sel(cpu_bgm_sel), .cpu_bgm_we(cpu_bgm_we),
    .fetch_bgm_addr(fetch_bgm_addr), .fetch_chr_addr(fetch_chr_addr),
    .bgm_rdata(bgm_rdata), .chr_rdata(chr_rdata),
    .rominit_sel_chr(rominit_sel_chr), .rominit_addr(rominit_addr),
    .rominit_data(rominit_data), .rominit_valid(rominit_valid)
  );

  bg_fetch i_bg_fetch (
    .CLK(CLK), .arst_n(arst_n), .CE(CE), .regs(regs), .raster(raster),
    .fetch_bgm_addr(fetch_bgm_addr), .fetch_chr_addr(fetch_chr_addr),
    .bgm_rdata(bgm_rdata), .chr_rdata(chr_rdata),
    .lb_we(lb_we), .lb_waddr(lb_waddr), .lb_wdata(lb_wdata)
  );

  line_buffer i_line_buffer (
    .CLK(CLK), .CE(CE), .lb_we(lb_we), .lb_waddr(lb_waddr),
    .lb_wdata(lb_wdata), .raster(raster), .px(px)
  );

  color_out i_color_out (
    .CLK(CLK), .arst_n(arst_n), .CE(CE), .px(px), .raster(raster), .rgb(rgb)
  );

endmodule

// File: logic/host_port.sv
////////////////////////////////////////////////////////////
// CPU side of the chip. Decodes the memory and register
// windows, holds the control registers and the read data
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module host_port (
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               CE,
  input  tv1_pkg::cpu_addr_t a,
  input  tv1_pkg::byte_t     db_i,
  input  logic               rdb,
  input  logic               wrb,
  input  logic               csb,
  output tv1_pkg::byte_t     db_o,
  output logic               db_oe,
  output logic               cpu_bgm_sel,
  output logic               cpu_bgm_we,
  input  tv1_pkg::byte_t     bgm_rdata,
  vid_regs_if.src            regs
);

  logic           cpu_rd;
  logic           cpu_wr;
  logic           sel_bgm;
  logic           sel_reg;
  tv1_pkg::byte_t ctrl [4];

  assign cpu_rd = ~(csb | rdb);
  assign cpu_wr = ~(csb | wrb);

  // $1000-$11FF and $1400-$15FF, registers mirror every 4 bytes
  assign sel_bgm = ~csb && (a[12:9] == tv1_pkg::ADDR_BGM_BASE[12:9]);
  assign sel_reg = ~csb && (a[12:9] == tv1_pkg::ADDR_REG_BASE[12:9]);

  assign cpu_bgm_sel = sel_bgm & (cpu_rd | cpu_wr);
  assign cpu_bgm_we  = sel_bgm & cpu_wr;
  assign db_oe       = cpu_rd;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 4; i++) begin
        ctrl[i] <= '0;
      end
    end else if (sel_reg && cpu_wr) begin
      ctrl[a[1:0]] <= db_i;
    end
  end

  // Read data, memory byte arrives one clock after the address
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      db_o <= '0;
    end else if (CE && cpu_rd) begin
      if (sel_bgm) begin
        db_o <= bgm_rdata;
      end else if (sel_reg) begin
        db_o <= ctrl[a[1:0]];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Register fields
  // Reg 0 bits 4 and 5 are the sprite controls, kept for read-back

  assign regs.bm_ena    = ctrl[0][0];
  assign regs.bm_lores  = ctrl[0][1];
  assign regs.bm_invx   = ctrl[0][6];
  assign regs.bm_invy   = ctrl[0][7];
  assign regs.bm_clr_bg = ctrl[1][3:0];
  assign regs.bm_clr_fg = ctrl[1][7:4];
  assign regs.bm_xmax   = ctrl[2][3:0];
  assign regs.bm_ymax   = ctrl[2][7:4];
  assign regs.ch_clr_bg = ctrl[3][3:0];
  assign regs.ch_clr_fg = ctrl[3][7:4];

endmodule

// File: logic/video_timing.sv
////////////////////////////////////////////////////////////
// Row and column counters, region flags and sync outputs,
// delayed two pixel steps to line up with the RGB output
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module video_timing (
  input  logic  CLK,
  input  logic  arst_n,
  input  logic  CE,
  output logic  vbl,
  output logic  de,
  output logic  hs,
  output logic  vs,
  raster_if.src raster
);

  tv1_pkg::coord_t row;
  tv1_pkg::coord_t col;
  logic            render_row;
  logic            render_px;
  logic            hs_s;
  logic            vs_s;
  logic            de_s;
  logic            vbl_s;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      row <= '0;
      col <= '0;
    end else if (CE) begin
      if (col == tv1_pkg::NUM_COLS - 9'd1) begin
        col <= '0;
        row <= (row == tv1_pkg::NUM_ROWS - 9'd1) ? '0 : row + 9'd1;
      end else begin
        col <= col + 9'd1;
      end
    end
  end

  assign render_row = (row >= tv1_pkg::FIRST_ROW_RENDER) && (row <= tv1_pkg::LAST_ROW_RENDER);
  assign render_px  = render_row && (col >= tv1_pkg::FIRST_COL_RENDER)
                      && (col <= tv1_pkg::LAST_COL_RENDER);

  assign raster.row       = row;
  assign raster.col       = col;
  assign raster.render_px = render_px;
  assign raster.fetch_row = (row >= tv1_pkg::FIRST_ROW_PREFETCH)
                            && (row < tv1_pkg::LAST_ROW_RENDER);

  // Stage 1 matches the line buffer read, stage 2 the palette register
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      hs_s  <= 1'b0;
      vs_s  <= 1'b0;
      de_s  <= 1'b0;
      vbl_s <= 1'b1;
      hs    <= 1'b0;
      vs    <= 1'b0;
      de    <= 1'b0;
      vbl   <= 1'b1;
    end else if (CE) begin
      hs_s  <= col <= tv1_pkg::LAST_COL_HSYNC;
      vs_s  <= (row >= tv1_pkg::FIRST_ROW_VSYNC) && (row <= tv1_pkg::LAST_ROW_VSYNC);
      de_s  <= render_px;
      vbl_s <= ~render_row;
      hs    <= hs_s;
      vs    <= vs_s;
      de    <= de_s;
      vbl   <= vbl_s;
    end
  end

endmodule

// File: project.f
common/tv1_pkg.sv
common/vid_regs_if.sv
common/raster_if.sv
logic/host_port.sv
logic/video_timing.sv
logic/color_out.sv
background/tile_memory.sv
background/bg_fetch.sv
background/line_buffer.sv
logic/epoch_tv1.sv
tests/epoch_tv1_sva.sv
tests/tb_epoch_tv1.sv

// File: tests/epoch_tv1_cases.txt
# R rom_addr data | W cpu_addr data | C cpu_addr expected_data | F capture next frame
# P display_line display_col expected_rgb, line and col in decimal, the rest in hex
R 008 a5
R 00b 0f
W 1400 30
W 1401 32
W 1402 ff
W 1403 f4
W 1045 81
W 1046 01
C 1400 30
C 1401 32
C 1402 ff
C 1403 f4
C 1045 81
C 1046 01
F
P 11 12 ffffff
P 11 13 00ff00
P 14 16 ffffff
P 14 12 00ff00
P 19 12 00ff00
P 11 20 ffffff
P 219 12 0000ff
W 1400 03
W 1402 11
F
P 11 12 ff0000
P 19 12 000000
P 11 20 00009b
W 1400 01
F
P 11 12 a100ff
P 11 16 0000ff
P 23 12 0000ff
P 23 16 a100ff
W 1400 41
W 1402 f3
F
P 11 12 a100ff
P 11 20 ffffff
W 1400 00
W 1402 11
C 1400 00
C 1402 11
F
P 0 0 0000ff
P 0 191 0000ff
P 221 0 0000ff
P 221 191 0000ff
P 11 12 0000ff

// File: tests/epoch_tv1_sva.sv
////////////////////////////////////////////////////////////
// Concurrent checks on the top level ports, bound into
// every instance of the video core
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module epoch_tv1_sva (
  input logic CLK,
  input logic arst_n,
  input logic csb,
  input logic rdb,
  input logic db_oe,
  input logic de,
  input logic vbl,
  input logic hs,
  input logic vs
);

  // Read data enable only inside a read strobe
  a_oe_in_read: assert property (@(posedge CLK) db_oe |-> (!csb && !rdb))
    else $error("db_oe high without an active read strobe");

  a_de_not_vbl: assert property (@(posedge CLK) !(de && vbl))
    else $error("de and vbl high together");

  // Sync and enable stay quiet through reset
  a_quiet_reset: assert property (@(posedge CLK) !arst_n |-> (!hs && !vs && !de))
    else $error("hs, vs or de active during reset");

endmodule

bind epoch_tv1 epoch_tv1_sva i_epoch_tv1_sva (
  .CLK(CLK), .arst_n(arst_n), .csb(csb), .rdb(rdb), .db_oe(db_oe),
  .de(de), .vbl(vbl), .hs(hs), .vs(vs)
);

// File: tests/tb_epoch_tv1.sv
////////////////////////////////////////////////////////////
// Testbench for the TV-1 background core. Runs the cases
// file line by line and checks reads, frame timing and pixels
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_epoch_tv1;

  logic               CLK;
  logic               arst_n;
  logic               CE;
  logic               rominit_sel_chr;
  tv1_pkg::chr_addr_t rominit_addr;
  tv1_pkg::byte_t     rominit_data;
  logic               rominit_valid;
  tv1_pkg::cpu_addr_t a;
  tv1_pkg::byte_t     db_i;
  logic               rdb;
  logic               wrb;
  logic               csb;
  tv1_pkg::byte_t     db_o;
  logic               db_oe;
  logic               vbl;
  logic               de;
  logic               hs;
  logic               vs;
  tv1_pkg::rgb_t      rgb;

  integer        seed;
  int            value_errs;
  int            timing_errs;
  int            other_errs;
  int            pixel_checks;
  logic          timed_out;
  // Last captured frame of 222 lines by 192 pixels
  tv1_pkg::rgb_t cap [222*192];
  // Current and previous pixel step samples
  logic          s_hs;
  logic          s_vs;
  logic          s_de;
  logic          s_vbl;
  logic          p_hs;
  logic          p_vs;
  logic          p_de;
  tv1_pkg::rgb_t s_rgb;

  epoch_tv1 i_epoch_tv1 (
    .CLK(CLK), .arst_n(arst_n), .CE(CE),
    .rominit_sel_chr(rominit_sel_chr), .rominit_addr(rominit_addr),
    .rominit_data(rominit_data), .rominit_valid(rominit_valid),
    .a(a), .db_i(db_i), .rdb(rdb), .wrb(wrb), .csb(csb),
    .db_o(db_o), .db_oe(db_oe),
    .vbl(vbl), .de(de), .hs(hs), .vs(vs), .rgb(rgb)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Pixel enable is high on about three clocks in four
  initial begin
    seed = 32'h5f6d_8de8;
    CE   = 1'b0;
    forever begin
      @(posedge CLK);
      CE <= ($random(seed) & 3) != 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sampling

  // Outputs advance on the next edge, so this step is sampled once
  task automatic next_step();
    int n;
    n    = 0;
    p_hs = s_hs;
    p_vs = s_vs;
    p_de = s_de;
    do begin
      @(negedge CLK);
      n++;
    end while (!CE && n < 1000);
    if (!CE) begin
      timed_out = 1'b1;
      $display("Timeout: CE stayed low for 1000 clocks");
    end
    s_hs  = hs;
    s_vs  = vs;
    s_de  = de;
    s_vbl = vbl;
    s_rgb = rgb;
  endtask

  // CPU accesses stay inside vertical sync and away from the fetch rows
  task automatic wait_vsync();
    int n;
    n = 0;
    do begin
      next_step();
      n++;
    end while (!s_vs && !timed_out && n < 80000);
    if (!s_vs && !timed_out) begin
      timed_out = 1'b1;
      $display("Timeout: no vertical sync seen within one frame");
    end
  endtask

  task automatic wait_vs_rise();
    int n;
    n = 0;
    do begin
      next_step();
      n++;
    end while (!(s_vs && !p_vs) && !timed_out && n < 80000);
    if (!(s_vs && !p_vs) && !timed_out) begin
      timed_out = 1'b1;
      $display("Timeout: no start of vertical sync within one frame");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and ROM load

  task automatic load_rom(input tv1_pkg::chr_addr_t addr, input tv1_pkg::byte_t data);
    @(posedge CLK);
    rominit_sel_chr <= 1'b1;
    rominit_valid   <= 1'b1;
    rominit_addr    <= addr;
    rominit_data    <= data;
    @(posedge CLK);
    rominit_sel_chr <= 1'b0;
    rominit_valid   <= 1'b0;
  endtask

  task automatic cpu_write(input tv1_pkg::cpu_addr_t addr, input tv1_pkg::byte_t data);
    wait_vsync();
    @(posedge CLK);
    a    <= addr;
    db_i <= data;
    csb  <= 1'b0;
    wrb  <= 1'b0;
    @(posedge CLK);
    csb  <= 1'b1;
    wrb  <= 1'b1;
  endtask

  task automatic cpu_read(input tv1_pkg::cpu_addr_t addr, input tv1_pkg::byte_t exp);
    wait_vsync();
    @(posedge CLK);
    a   <= addr;
    csb <= 1'b0;
    rdb <= 1'b0;
    // Valid after the second CE edge of the strobe
    next_step();
    next_step();
    @(posedge CLK);
    @(negedge CLK);
    if (db_oe !== 1'b1) begin
      value_errs++;
      $display("[ERROR] db_oe during read of %h: got %h expected 1", addr, db_oe);
    end
    if (db_o !== exp) begin
      value_errs++;
      $display("[ERROR] db_o at %h: got %h expected %h", addr, db_o, exp);
    end
    @(posedge CLK);
    csb <= 1'b1;
    rdb <= 1'b1;
    @(negedge CLK);
    if (db_oe !== 1'b0) begin
      value_errs++;
      $display("[ERROR] db_oe after read of %h: got %h expected 0", addr, db_oe);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Frame capture and timing counts

  task automatic capture_frame();
    int de_line;
    int de_col;
    int hs_run;
    int lines;
    int vs_lines;
    int vbl_lines;
    int steps;
    de_line   = 0;
    de_col    = 0;
    hs_run    = 0;
    lines     = 0;
    vs_lines  = 0;
    vbl_lines = 0;
    steps     = 0;
    for (int i = 0; i < 222*192; i++) begin
      cap[i] = 'x;
    end
    wait_vs_rise();
    // One frame from one start of vertical sync to the next
    do begin
      if (s_hs && !p_hs) begin
        lines++;
        if (s_vs) vs_lines++;
        if (s_vbl) vbl_lines++;
      end
      if (s_hs) begin
        hs_run++;
      end else if (p_hs) begin
        if (hs_run != 20) begin
          timing_errs++;
          $display("[ERROR] hs pulse: got %0h steps expected %0h", hs_run, 20);
        end
        hs_run = 0;
      end
      if (s_de) begin
        if (de_line < 222 && de_col < 192) cap[de_line*192 + de_col] = s_rgb;
        de_col++;
      end else if (p_de) begin
        if (de_col != 192) begin
          timing_errs++;
          $display("[ERROR] de on line %0d: got %0h pixels expected %0h", de_line, de_col, 192);
        end
        de_line++;
        de_col = 0;
      end
      next_step();
      steps++;
    end while (!(s_vs && !p_vs) && !timed_out && steps < 80000);
    if (steps >= 80000) begin
      timed_out = 1'b1;
      $display("Timeout: frame did not end within 80000 pixel steps");
    end
    if (lines != 262 || de_line != 222 || vs_lines != 9 || vbl_lines != 40) begin
      timing_errs++;
      $display("[ERROR] frame lines: total %0h de %0h vs %0h vbl %0h expected %0h %0h %0h %0h",
               lines, de_line, vs_lines, vbl_lines, 262, 222, 9, 40);
    end
  endtask

  task automatic check_pixel(input int line, input int col, input tv1_pkg::rgb_t exp);
    pixel_checks++;
    if (line >= 222 || col >= 192) begin
      other_errs++;
      $display("Pixel at line %0d column %0d lies outside the display", line, col);
    end else if (cap[line*192 + col] !== exp) begin
      value_errs++;
      $display("[ERROR] rgb at line %0d col %0d: got %h expected %h",
               line, col, cap[line*192 + col], exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cases file

  task automatic flag_bad_line(input logic [7:0] kind);
    other_errs++;
    $display("Line of kind %c in the cases file has missing or bad operands", kind);
  endtask

  task automatic run_cases();
    integer           fd;
    integer           rc;
    logic [7:0]       kind;
    logic [31:0]      op1;
    logic [31:0]      op2;
    logic [31:0]      op3;
    logic [8*256-1:0] text;
    fd = $fopen("tests/epoch_tv1_cases.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Could not open tests/epoch_tv1_cases.txt");
      return;
    end
    while (!timed_out && $fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": rc = $fgets(text, fd);
        "R": begin
          rc = $fscanf(fd, "%h %h", op1, op2);
          if (rc != 2) begin
            flag_bad_line(kind);
          end else begin
            load_rom(op1[9:0], op2[7:0]);
          end
        end
        "W": begin
          rc = $fscanf(fd, "%h %h", op1, op2);
          if (rc != 2) begin
            flag_bad_line(kind);
          end else begin
            cpu_write(op1[12:0], op2[7:0]);
          end
        end
        "C": begin
          rc = $fscanf(fd, "%h %h", op1, op2);
          if (rc != 2) begin
            flag_bad_line(kind);
          end else begin
            cpu_read(op1[12:0], op2[7:0]);
          end
        end
        "P": begin
          rc = $fscanf(fd, "%d %d %h", op1, op2, op3);
          if (rc != 3) begin
            flag_bad_line(kind);
          end else begin
            check_pixel(op1, op2, op3[23:0]);
          end
        end
        "F": capture_frame();
        default: begin
          other_errs++;
          $display("Unknown line kind %c in the cases file", kind);
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    arst_n          = 1'b0;
    rominit_sel_chr = 1'b0;
    rominit_addr    = '0;
    rominit_data    = '0;
    rominit_valid   = 1'b0;
    a               = '0;
    db_i            = '0;
    rdb             = 1'b1;
    wrb             = 1'b1;
    csb             = 1'b1;
    value_errs      = 0;
    timing_errs     = 0;
    other_errs      = 0;
    pixel_checks    = 0;
    timed_out       = 1'b0;
    {s_hs, s_vs, s_de, s_vbl, p_hs, p_vs, p_de} = '0;
    s_rgb           = '0;
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    if (vbl !== 1'b1 || de !== 1'b0 || hs !== 1'b0 || vs !== 1'b0 || db_oe !== 1'b0) begin
      value_errs++;
      $display("[ERROR] outputs in reset: vbl %h de %h hs %h vs %h db_oe %h expected 1 0 0 0 0",
               vbl, de, hs, vs, db_oe);
    end
    @(posedge CLK);
    arst_n <= 1'b1;
    run_cases();
    if (pixel_checks == 0) begin
      other_errs++;
      $display("No pixel was checked");
    end
    if (timed_out) other_errs++;
    $display("Errors: value %0d, timing %0d, other %0d", value_errs, timing_errs, other_errs);
    if (value_errs + timing_errs + other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
